/* hw/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // Datapath and field widths
    localparam int XLEN     = 32;
    localparam int REG_AW   = 5;
    localparam int OPC_W    = 7;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [OPC_W-1:0]  opcode_t;

    // Major opcodes of the supported subset
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;

    // First fetch address
    localparam word_t RESET_PC = 32'h0001_0000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        // LUI passes the immediate through
        ALU_PASS_B
    } alu_op_e;

    // Source of a decode operand
    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EX,
        FWD_MEM
    } fwd_sel_e;

endpackage

`default_nettype wire

/* hw/rv_decode.sv */
`default_nettype none

module rv_decode (
    input  wire rv_pkg::word_t instr,
    output rv_pkg::reg_addr_t  rs1,
    output rv_pkg::reg_addr_t  rs2,
    output rv_pkg::reg_addr_t  rd,
    output rv_pkg::opcode_t    opcode,
    output rv_pkg::word_t      imm,
    output rv_pkg::alu_op_e    alu_op,
    output logic               use_imm,
    output logic               reg_write,
    output logic               is_load,
    output logic               is_store
);

    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    always_comb begin
        imm       = '0;
        alu_op    = rv_pkg::ALU_ADD;
        use_imm   = 1'b0;
        reg_write = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        case (opcode)
            rv_pkg::OPC_LUI: begin
                imm       = {instr[31:12], 12'b0};
                alu_op    = rv_pkg::ALU_PASS_B;
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            rv_pkg::OPC_OP_IMM: begin
                imm       = {{20{instr[31]}}, instr[31:20]};
                use_imm   = 1'b1;
                reg_write = 1'b1;
                case (funct3)
                    3'b000:  alu_op = rv_pkg::ALU_ADD;
                    3'b010:  alu_op = rv_pkg::ALU_SLT;
                    3'b100:  alu_op = rv_pkg::ALU_XOR;
                    3'b110:  alu_op = rv_pkg::ALU_OR;
                    3'b111:  alu_op = rv_pkg::ALU_AND;
                    // Shifts and unsigned compares are no-ops
                    default: reg_write = 1'b0;
                endcase
            end
            rv_pkg::OPC_OP: begin
                reg_write = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: alu_op = rv_pkg::ALU_ADD;
                    {7'h20, 3'b000}: alu_op = rv_pkg::ALU_SUB;
                    {7'h00, 3'b010}: alu_op = rv_pkg::ALU_SLT;
                    {7'h00, 3'b100}: alu_op = rv_pkg::ALU_XOR;
                    {7'h00, 3'b110}: alu_op = rv_pkg::ALU_OR;
                    {7'h00, 3'b111}: alu_op = rv_pkg::ALU_AND;
                    default:         reg_write = 1'b0;
                endcase
            end
            rv_pkg::OPC_LOAD: begin
                imm       = {{20{instr[31]}}, instr[31:20]};
                use_imm   = 1'b1;
                reg_write = 1'b1;
                is_load   = 1'b1;
            end
            rv_pkg::OPC_STORE: begin
                imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                use_imm  = 1'b1;
                is_store = 1'b1;
            end
            rv_pkg::OPC_BRANCH: begin
                imm    = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                          instr[11:8], 1'b0};
                alu_op = rv_pkg::ALU_SUB;
            end
            rv_pkg::OPC_JAL: begin
                imm       = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                             instr[30:21], 1'b0};
                reg_write = 1'b1;
            end
            default: begin
                // Unknown opcode leaves everything cleared
                reg_write = 1'b0;
            end
        endcase
        // Writes to x0 are dropped here
        if (rd == '0) begin
            reg_write = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/rv_regfile.sv */
`default_nettype none

module rv_regfile (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire rv_pkg::reg_addr_t rs1,
    input  wire rv_pkg::reg_addr_t rs2,
    output rv_pkg::word_t          rd1,
    output rv_pkg::word_t          rd2,
    input  wire                    we,
    input  wire rv_pkg::reg_addr_t wa,
    input  wire rv_pkg::word_t     wd
);

    // x0 has no storage
    rv_pkg::word_t regs [1:rv_pkg::NUM_REGS-1];

    function automatic rv_pkg::word_t read_port(rv_pkg::reg_addr_t ra);
        if (ra == '0) begin
            return '0;
        end
        // Write-through of the write-back value
        if (we && wa == ra) begin
            return wd;
        end
        return regs[ra];
    endfunction

    always_comb begin
        rd1 = read_port(rs1);
        rd2 = read_port(rs2);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < rv_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

endmodule

`default_nettype wire

/* hw/rv_hazard.sv */
`default_nettype none

module rv_hazard (
    input  wire rv_pkg::reg_addr_t rs1,
    input  wire rv_pkg::reg_addr_t rs2,
    input  wire rv_pkg::reg_addr_t ex_rd,
    input  wire                    ex_reg_write,
    input  wire                    ex_is_load,
    input  wire rv_pkg::reg_addr_t mem_rd,
    input  wire                    mem_reg_write,
    output rv_pkg::fwd_sel_e       fwd_a,
    output rv_pkg::fwd_sel_e       fwd_b,
    output logic                   stall
);

    logic ex_fwd_ok;
    logic mem_fwd_ok;

    // A load in execute has no data yet
    assign ex_fwd_ok  = ex_reg_write && !ex_is_load && ex_rd != '0;
    assign mem_fwd_ok = mem_reg_write && mem_rd != '0;

    function automatic rv_pkg::fwd_sel_e pick_src(rv_pkg::reg_addr_t rs);
        if (ex_fwd_ok && rs == ex_rd) begin
            return rv_pkg::FWD_EX;
        end
        if (mem_fwd_ok && rs == mem_rd) begin
            return rv_pkg::FWD_MEM;
        end
        return rv_pkg::FWD_RF;
    endfunction

    always_comb begin
        fwd_a = pick_src(rs1);
        fwd_b = pick_src(rs2);
    end

    // Load-use: hold decode one cycle until the word reaches memory stage
    assign stall = ex_is_load && ex_reg_write && ex_rd != '0 &&
                   (rs1 == ex_rd || rs2 == ex_rd);

endmodule

`default_nettype wire

/* hw/rv_execute.sv */
`default_nettype none

module rv_execute (
    input  wire rv_pkg::word_t   pc,
    input  wire rv_pkg::word_t   op_a,
    input  wire rv_pkg::word_t   op_b,
    input  wire rv_pkg::word_t   imm,
    input  wire rv_pkg::alu_op_e alu_op,
    input  wire                  use_imm,
    input  wire rv_pkg::opcode_t opcode,
    input  wire                  is_bne,
    output rv_pkg::word_t        result,
    output logic                 taken,
    output rv_pkg::word_t        target
);

    rv_pkg::word_t alu_b;
    logic          equal;

    assign alu_b = use_imm ? imm : op_b;

    always_comb begin
        case (alu_op)
            rv_pkg::ALU_ADD:    result = op_a + alu_b;
            rv_pkg::ALU_SUB:    result = op_a - alu_b;
            rv_pkg::ALU_AND:    result = op_a & alu_b;
            rv_pkg::ALU_OR:     result = op_a | alu_b;
            rv_pkg::ALU_XOR:    result = op_a ^ alu_b;
            rv_pkg::ALU_SLT: begin
                result = {31'b0, $signed(op_a) < $signed(alu_b)};
            end
            rv_pkg::ALU_PASS_B: result = alu_b;
            default:            result = '0;
        endcase
    end

    // Branch compare always uses the register operands
    assign equal = op_a == op_b;

    always_comb begin
        case (opcode)
            rv_pkg::OPC_JAL:    taken = 1'b1;
            rv_pkg::OPC_BRANCH: taken = is_bne ? !equal : equal;
            default:            taken = 1'b0;
        endcase
    end

    // Same adder serves BEQ, BNE and JAL
    assign target = pc + imm;

endmodule

`default_nettype wire

/* hw/rv_mem_stage.sv */
`default_nettype none

module rv_mem_stage (
    input  wire                valid,
    input  wire                is_load,
    input  wire                is_store,
    input  wire rv_pkg::word_t alu_result,
    input  wire rv_pkg::word_t store_data,
    output rv_pkg::word_t      dad,
    inout  wire rv_pkg::word_t ddt,
    output logic               mreq,
    output logic               write,
    output rv_pkg::word_t      stage_result
);

    assign mreq  = valid && (is_load || is_store);
    assign write = valid && is_store;

    // Word address straight from the ALU
    assign dad = alu_result;

    // Bus turned around only for stores
    assign ddt = write ? store_data : 'z;

    // Memory answers a read in the same cycle
    assign stage_result = is_load ? ddt : alu_result;

endmodule

`default_nettype wire

/* hw/rv_core.sv */
`default_nettype none

module rv_core (
    input  wire                clk,
    input  wire                arst_n,
    output rv_pkg::word_t      iad,
    input  wire rv_pkg::word_t idt,
    output wire rv_pkg::word_t dad,
    inout  wire rv_pkg::word_t ddt,
    output wire                mreq,
    output wire                write
);

    rv_pkg::word_t     pc;
    logic              if_id_valid;
    rv_pkg::word_t     if_id_pc;
    rv_pkg::word_t     if_id_instr;

    rv_pkg::reg_addr_t dec_rs1, dec_rs2, dec_rd;
    rv_pkg::opcode_t   dec_opcode;
    rv_pkg::word_t     dec_imm;
    rv_pkg::alu_op_e   dec_alu_op;
    logic              dec_use_imm, dec_reg_write, dec_is_load, dec_is_store;
    logic              dec_take;

    rv_pkg::word_t     rf_rd1, rf_rd2;
    rv_pkg::fwd_sel_e  fwd_a, fwd_b;
    logic              stall;
    rv_pkg::word_t     op_a, op_b;

    logic              id_ex_valid, id_ex_reg_write, id_ex_is_load, id_ex_is_store;
    rv_pkg::word_t     id_ex_pc, id_ex_op_a, id_ex_op_b, id_ex_imm;
    rv_pkg::alu_op_e   id_ex_alu_op;
    logic              id_ex_use_imm, id_ex_is_bne;
    rv_pkg::opcode_t   id_ex_opcode;
    rv_pkg::reg_addr_t id_ex_rd;

    rv_pkg::word_t     ex_result, ex_target;
    logic              ex_taken, flush;

    logic              ex_mem_valid, ex_mem_reg_write, ex_mem_is_load, ex_mem_is_store;
    rv_pkg::word_t     ex_mem_pc4, ex_mem_result, ex_mem_store_data;
    rv_pkg::reg_addr_t ex_mem_rd;
    logic              ex_mem_is_jal;
    rv_pkg::word_t     mem_result;
    rv_pkg::word_t     mem_fwd;

    logic              mem_wb_valid, mem_wb_reg_write, mem_wb_is_jal;
    rv_pkg::word_t     mem_wb_pc4, mem_wb_result;
    rv_pkg::reg_addr_t mem_wb_rd;
    rv_pkg::word_t     wb_data;
    logic              wb_we;

    // Fetch
    assign iad = pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= rv_pkg::RESET_PC;
        end else if (flush) begin
            pc <= ex_target;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            if_id_valid <= 1'b0;
        end else if (flush) begin
            if_id_valid <= 1'b0;
        end else if (!stall) begin
            if_id_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_id_pc    <= pc;
            if_id_instr <= idt;
        end
    end

    // Decode
    rv_decode rv_decode_i (
        .instr     (if_id_instr),
        .rs1       (dec_rs1),
        .rs2       (dec_rs2),
        .rd        (dec_rd),
        .opcode    (dec_opcode),
        .imm       (dec_imm),
        .alu_op    (dec_alu_op),
        .use_imm   (dec_use_imm),
        .reg_write (dec_reg_write),
        .is_load   (dec_is_load),
        .is_store  (dec_is_store)
    );

    rv_regfile rv_regfile_i (
        .clk    (clk),
        .arst_n (arst_n),
        .rs1    (dec_rs1),
        .rs2    (dec_rs2),
        .rd1    (rf_rd1),
        .rd2    (rf_rd2),
        .we     (wb_we),
        .wa     (mem_wb_rd),
        .wd     (wb_data)
    );

    rv_hazard rv_hazard_i (
        .rs1           (dec_rs1),
        .rs2           (dec_rs2),
        .ex_rd         (id_ex_rd),
        .ex_reg_write  (id_ex_reg_write),
        .ex_is_load    (id_ex_is_load),
        .mem_rd        (ex_mem_rd),
        .mem_reg_write (ex_mem_reg_write),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .stall         (stall)
    );

    function automatic rv_pkg::word_t pick_operand(rv_pkg::fwd_sel_e sel,
                                                   rv_pkg::word_t rf_val,
                                                   rv_pkg::word_t ex_val,
                                                   rv_pkg::word_t mem_val);
        case (sel)
            rv_pkg::FWD_EX:  return ex_val;
            rv_pkg::FWD_MEM: return mem_val;
            default:         return rf_val;
        endcase
    endfunction

    // A JAL in memory stage forwards its link address
    assign mem_fwd = ex_mem_is_jal ? ex_mem_pc4 : mem_result;

    assign op_a = pick_operand(fwd_a, rf_rd1, ex_result, mem_fwd);
    assign op_b = pick_operand(fwd_b, rf_rd2, ex_result, mem_fwd);

    // Bubble on stall, flush or empty decode slot
    assign dec_take = if_id_valid && !stall && !flush;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex_valid     <= 1'b0;
            id_ex_reg_write <= 1'b0;
            id_ex_is_load   <= 1'b0;
            id_ex_is_store  <= 1'b0;
        end else begin
            id_ex_valid     <= dec_take;
            id_ex_reg_write <= dec_take && dec_reg_write;
            id_ex_is_load   <= dec_take && dec_is_load;
            id_ex_is_store  <= dec_take && dec_is_store;
        end
    end

    always_ff @(posedge clk) begin
        id_ex_pc      <= if_id_pc;
        id_ex_op_a    <= op_a;
        id_ex_op_b    <= op_b;
        id_ex_imm     <= dec_imm;
        id_ex_alu_op  <= dec_alu_op;
        id_ex_use_imm <= dec_use_imm;
        id_ex_opcode  <= dec_opcode;
        id_ex_is_bne  <= if_id_instr[12];
        id_ex_rd      <= dec_rd;
    end

    // Execute
    rv_execute rv_execute_i (
        .pc      (id_ex_pc),
        .op_a    (id_ex_op_a),
        .op_b    (id_ex_op_b),
        .imm     (id_ex_imm),
        .alu_op  (id_ex_alu_op),
        .use_imm (id_ex_use_imm),
        .opcode  (id_ex_opcode),
        .is_bne  (id_ex_is_bne),
        .result  (ex_result),
        .taken   (ex_taken),
        .target  (ex_target)
    );

    assign flush = id_ex_valid && ex_taken;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem_valid     <= 1'b0;
            ex_mem_reg_write <= 1'b0;
            ex_mem_is_load   <= 1'b0;
            ex_mem_is_store  <= 1'b0;
        end else begin
            ex_mem_valid     <= id_ex_valid;
            ex_mem_reg_write <= id_ex_reg_write;
            ex_mem_is_load   <= id_ex_is_load;
            ex_mem_is_store  <= id_ex_is_store;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem_pc4        <= id_ex_pc + 32'd4;
        ex_mem_result     <= ex_result;
        ex_mem_store_data <= id_ex_op_b;
        ex_mem_rd         <= id_ex_rd;
        ex_mem_is_jal     <= id_ex_opcode == rv_pkg::OPC_JAL;
    end

    // Memory
    rv_mem_stage rv_mem_stage_i (
        .valid        (ex_mem_valid),
        .is_load      (ex_mem_is_load),
        .is_store     (ex_mem_is_store),
        .alu_result   (ex_mem_result),
        .store_data   (ex_mem_store_data),
        .dad          (dad),
        .ddt          (ddt),
        .mreq         (mreq),
        .write        (write),
        .stage_result (mem_result)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb_valid     <= 1'b0;
            mem_wb_reg_write <= 1'b0;
        end else begin
            mem_wb_valid     <= ex_mem_valid;
            mem_wb_reg_write <= ex_mem_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        mem_wb_result <= mem_result;
        mem_wb_pc4    <= ex_mem_pc4;
        mem_wb_rd     <= ex_mem_rd;
        mem_wb_is_jal <= ex_mem_is_jal;
    end

    // Write-back, JAL links the return address
    assign wb_data = mem_wb_is_jal ? mem_wb_pc4 : mem_wb_result;
    assign wb_we   = mem_wb_valid && mem_wb_reg_write;

endmodule

`default_nettype wire

/* bench/rv_core_checker.sv */
`default_nettype none

module rv_core_checker (
    input wire                clk,
    input wire                arst_n,
    input wire                mreq,
    input wire                write,
    input wire rv_pkg::word_t dad
);
    timeunit 1ns;
    timeprecision 1ps;

    // A store is always a memory request
    write_needs_mreq: assert property (
        @(posedge clk) disable iff (!arst_n) write |-> mreq
    ) else $error("write high while mreq is low");

    // Only whole words are accessed
    dad_word_aligned: assert property (
        @(posedge clk) disable iff (!arst_n)
        mreq |-> (!$isunknown(dad) && dad[1:0] == 2'b00)
    ) else $error("dad unknown or not word aligned during an access");

    bus_quiet_in_reset: assert property (
        @(posedge clk) !arst_n |-> (!mreq && !write)
    ) else $error("memory strobes active during reset");

endmodule

bind rv_core rv_core_checker rv_core_checker_i (
    .clk    (clk),
    .arst_n (arst_n),
    .mreq   (mreq),
    .write  (write),
    .dad    (dad)
);

`default_nettype wire

/* bench/rv_core_tb.sv */
`default_nettype none

module rv_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int            CLK_PERIOD     = 40;
    localparam int            DRIVE_DELAY    = 5;
    localparam int            RESET_CYCLES   = 16;
    localparam int            PROG_LEN       = 200;
    localparam int            DMEM_WORDS     = 64;
    localparam int            TIMEOUT_CYCLES = 4 * PROG_LEN + 100;
    localparam int            END_HITS       = 10;
    localparam logic [31:0]   LFSR_SEED      = 32'h4ee77177;
    localparam rv_pkg::word_t FINAL_PC       = rv_pkg::RESET_PC + 4 * (PROG_LEN - 1);
    // ADDI x0, x0, 0
    localparam rv_pkg::word_t NOP            = 32'h0000_0013;

    logic               clk;
    logic               arst_n;
    wire rv_pkg::word_t iad;
    rv_pkg::word_t      idt;
    wire rv_pkg::word_t dad;
    wire rv_pkg::word_t ddt;
    wire                mreq;
    wire                write;

    rv_pkg::word_t prog [PROG_LEN];
    rv_pkg::word_t dmem [DMEM_WORDS];
    rv_pkg::word_t exp_addr [$];
    rv_pkg::word_t exp_data [$];
    logic [31:0]   lfsr;
    int            cycles;
    int            stores_seen;
    int            end_hits;
    logic          done;

    rv_core rv_core_i (
        .clk    (clk),
        .arst_n (arst_n),
        .iad    (iad),
        .idt    (idt),
        .dad    (dad),
        .ddt    (ddt),
        .mreq   (mreq),
        .write  (write)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic fail_run();
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(string name, rv_pkg::word_t got, rv_pkg::word_t exp);
        if (got !== exp) begin
            $display("Error: %s is %h, expected %h", name, got, exp);
            fail_run();
        end
    endtask

    // Instruction memory, answers in the same cycle
    function automatic rv_pkg::word_t fetch_word(rv_pkg::word_t addr);
        rv_pkg::word_t offset;
        offset = addr - rv_pkg::RESET_PC;
        if (addr >= rv_pkg::RESET_PC && offset < 4 * PROG_LEN) begin
            return prog[offset[31:2]];
        end
        return NOP;
    endfunction

    always_comb begin
        idt = fetch_word(iad);
    end

    // Data memory, read on ddt and write at the closing edge
    assign ddt = (mreq === 1'b1 && write === 1'b0) ? dmem[dad[7:2]] : 'z;

    always @(posedge clk) begin
        if (mreq === 1'b1 && write === 1'b1) begin
            dmem[dad[7:2]] <= ddt;
        end
    end

    task automatic fill_data_memory();
        for (int k = 0; k < DMEM_WORDS; k++) begin
            dmem[k] = take_bits(32);
        end
    endtask

    task automatic build_program();
        logic [3:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] r;
        logic [11:0] mimm;
        logic [20:0] jimm;
        int          sel;
        int          off;
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            kind = 4'(take_bits(4));
            // Few registers so dependencies come up often
            rd  = 5'(take_bits(3));
            rs1 = 5'(take_bits(3));
            rs2 = 5'(take_bits(3));
            if (kind >= 14 && i > PROG_LEN - 3) begin
                kind = 4'd6;
            end
            case (kind)
                0, 1: begin
                    r = take_bits(20);
                    prog[i] = {r[19:0], rd, rv_pkg::OPC_LUI};
                end
                2, 3, 4, 5: begin
                    case (take_bits(2))
                        0:       f3 = 3'b000;
                        1:       f3 = 3'b100;
                        2:       f3 = 3'b110;
                        default: f3 = 3'b111;
                    endcase
                    r = take_bits(12);
                    prog[i] = {r[11:0], rs1, f3, rd, rv_pkg::OPC_OP_IMM};
                end
                6, 7, 8: begin
                    sel = int'(take_bits(3)) % 6;
                    f7  = (sel == 1) ? 7'h20 : 7'h00;
                    case (sel)
                        2:       f3 = 3'b111;
                        3:       f3 = 3'b110;
                        4:       f3 = 3'b100;
                        5:       f3 = 3'b010;
                        default: f3 = 3'b000;
                    endcase
                    prog[i] = {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
                end
                9, 10: begin
                    r = take_bits(6);
                    mimm = {4'b0, r[5:0], 2'b00};
                    prog[i] = {mimm, 5'd0, 3'b010, rd, rv_pkg::OPC_LOAD};
                end
                11, 12, 13: begin
                    r = take_bits(6);
                    mimm = {4'b0, r[5:0], 2'b00};
                    prog[i] = {mimm[11:5], rs2, 5'd0, 3'b010, mimm[4:0], rv_pkg::OPC_STORE};
                end
                default: begin
                    // Forward by 2 to 8, never past the closing jump
                    off = 2 + int'(take_bits(3)) % 7;
                    if (i + off > PROG_LEN - 1) begin
                        off = PROG_LEN - 1 - i;
                    end
                    jimm = 21'(off * 4);
                    if (kind == 14) begin
                        r = take_bits(1);
                        prog[i] = {jimm[12], jimm[10:5], rs2, rs1, 2'b00, r[0],
                                   jimm[4:1], jimm[11], rv_pkg::OPC_BRANCH};
                    end else begin
                        prog[i] = {jimm[20], jimm[10:1], jimm[11], jimm[19:12], rd,
                                   rv_pkg::OPC_JAL};
                    end
                end
            endcase
        end
        // JAL x0, 0 spins on itself
        prog[PROG_LEN - 1] = {25'd0, rv_pkg::OPC_JAL};
    endtask

    function automatic rv_pkg::word_t isa_alu(logic [2:0] f3, logic alt,
                                              rv_pkg::word_t a, rv_pkg::word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Sequential interpreter of the program, records every store in order
    task automatic run_model();
        rv_pkg::word_t x [32];
        rv_pkg::word_t mem [DMEM_WORDS];
        rv_pkg::word_t w;
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        rv_pkg::word_t res;
        rv_pkg::word_t addr;
        rv_pkg::word_t ii;
        rv_pkg::word_t si;
        rv_pkg::word_t bi;
        rv_pkg::word_t ji;
        logic          wr;
        int            idx;
        int            nxt;
        for (int k = 0; k < 32; k++) begin
            x[k] = '0;
        end
        mem = dmem;
        idx = 0;
        while (idx != PROG_LEN - 1) begin
            w   = prog[idx];
            a   = x[w[19:15]];
            b   = x[w[24:20]];
            ii  = {{20{w[31]}}, w[31:20]};
            si  = {{20{w[31]}}, w[31:25], w[11:7]};
            bi  = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            ji  = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            nxt = idx + 1;
            wr  = 1'b1;
            res = '0;
            case (w[6:0])
                rv_pkg::OPC_LUI:    res = {w[31:12], 12'h000};
                rv_pkg::OPC_OP_IMM: res = isa_alu(w[14:12], 1'b0, a, ii);
                rv_pkg::OPC_OP:     res = isa_alu(w[14:12], w[30], a, b);
                rv_pkg::OPC_LOAD: begin
                    addr = a + ii;
                    res  = mem[addr[7:2]];
                end
                rv_pkg::OPC_STORE: begin
                    wr   = 1'b0;
                    addr = a + si;
                    mem[addr[7:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                rv_pkg::OPC_BRANCH: begin
                    wr = 1'b0;
                    if ((a == b) != w[12]) begin
                        nxt = idx + int'($signed(bi) >>> 2);
                    end
                end
                rv_pkg::OPC_JAL: begin
                    res = rv_pkg::RESET_PC + 32'(4 * (idx + 1));
                    nxt = idx + int'($signed(ji) >>> 2);
                end
                default: wr = 1'b0;
            endcase
            if (wr && w[11:7] != 5'd0) begin
                x[w[11:7]] = res;
            end
            idx = nxt;
        end
    endtask

    // Bus checks at the falling edge, where the outputs are settled
    always @(negedge clk) begin
        if (arst_n) begin
            cycles = cycles + 1;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("Timeout: the core did not reach its final jump within %0d cycles",
                         TIMEOUT_CYCLES);
                fail_run();
            end else begin
                if (cycles == 1) begin
                    check_value("iad", iad, rv_pkg::RESET_PC);
                end
                // The first instruction needs three cycles to reach memory
                if (cycles <= 3) begin
                    check_value("mreq", mreq, 1'b0);
                end
                if (mreq === 1'b1 && write === 1'b1) begin
                    if (stores_seen >= exp_addr.size()) begin
                        $display("A store to address %h came after all %0d expected stores",
                                 dad, exp_addr.size());
                        fail_run();
                    end else begin
                        check_value("dad", dad, exp_addr[stores_seen]);
                        check_value("ddt", ddt, exp_data[stores_seen]);
                        stores_seen = stores_seen + 1;
                    end
                end
                // The closing JAL keeps coming back to its own address
                if (iad == FINAL_PC) begin
                    end_hits = end_hits + 1;
                end
                if (end_hits >= END_HITS) begin
                    done = 1'b1;
                end
            end
        end
    end

    initial begin
        arst_n      = 1'b1;
        lfsr        = LFSR_SEED;
        cycles      = 0;
        stores_seen = 0;
        end_hits    = 0;
        done        = 1'b0;
        fill_data_memory();
        build_program();
        run_model();
        // Clean falling reset edge once every process is running
        #1;
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        arst_n = 1'b1;
        wait (done);
        if (stores_seen == exp_addr.size()) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            check_value("stores_seen", stores_seen, exp_addr.size());
        end
    end

endmodule

`default_nettype wire

/* src.f */
hw/rv_pkg.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_hazard.sv
hw/rv_execute.sv
hw/rv_mem_stage.sv
hw/rv_core.sv
bench/rv_core_checker.sv
bench/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - files:
      - hw/rv_pkg.sv
      - hw/rv_decode.sv
      - hw/rv_regfile.sv
      - hw/rv_hazard.sv
      - hw/rv_execute.sv
      - hw/rv_mem_stage.sv
      - hw/rv_core.sv
  - target: test
    files:
      - bench/rv_core_checker.sv
      - bench/rv_core_tb.sv
